// ==== gfx_vga_pkg.sv ====
`default_nettype none

package gfx_vga_pkg;

  // tiny 16x8 video mode, keeps a frame at a few hundred positions
  localparam int H_VISIBLE     = 16;
  localparam int H_FRONT_PORCH = 2;
  localparam int H_SYNC_PULSE  = 3;
  localparam int H_BACK_PORCH  = 3;
  localparam int H_WHOLE_LINE  = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;

  localparam int V_VISIBLE     = 8;
  localparam int V_FRONT_PORCH = 1;
  localparam int V_SYNC_PULSE  = 2;
  localparam int V_BACK_PORCH  = 1;
  localparam int V_WHOLE_FRAME = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

  localparam int FRAME_POSITIONS = H_WHOLE_LINE * V_WHOLE_FRAME;

  // pixel is r, g, b channels followed by meta bits
  localparam int COLOR_BITS = 4;
  localparam int META_BITS  = 4;
  localparam int PIXEL_BITS = 3 * COLOR_BITS + META_BITS;
  localparam int FB_DEPTH   = H_VISIBLE * V_VISIBLE;

  localparam int FIFO_ADDR_BITS       = 4;
  localparam int FIFO_DEPTH           = 1 << FIFO_ADDR_BITS;
  localparam int FIFO_ALMOST_FULL_BUF = 8;

  typedef logic [$clog2(H_VISIBLE)-1:0]     fb_x_t;
  typedef logic [$clog2(V_VISIBLE)-1:0]     fb_y_t;
  typedef logic [$clog2(H_WHOLE_LINE)-1:0]  hcount_t;
  typedef logic [$clog2(V_WHOLE_FRAME)-1:0] vcount_t;
  typedef logic [$clog2(FB_DEPTH)-1:0]      fb_addr_t;
  typedef logic [COLOR_BITS-1:0]            color_t;
  typedef logic [META_BITS-1:0]             meta_t;
  typedef logic [PIXEL_BITS-1:0]            pixel_t;
  // hsync, vsync, then the pixel
  typedef logic [PIXEL_BITS+1:0]            vga_word_t;

endpackage

`default_nettype wire

// ==== fb_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_writer
  import gfx_vga_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  fb_x_t                   gfx_x,
  input  fb_y_t                   gfx_y,
  input  logic [3*COLOR_BITS-1:0] gfx_color,
  input  meta_t                   gfx_meta,
  input  logic                    gfx_valid,
  output logic                    gfx_ready,
  output logic                    wr_req,
  output fb_addr_t                wr_addr,
  output pixel_t                  wr_data,
  input  logic                    wr_grant
);

  logic pend_valid;
  logic accept;

  // slot frees up in the same cycle it is granted
  assign gfx_ready = !pend_valid || wr_grant;
  assign accept    = gfx_valid && gfx_ready;
  assign wr_req    = pend_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_valid <= 1'b0;
    end else if (accept) begin
      pend_valid <= 1'b1;
    end else if (wr_grant) begin
      pend_valid <= 1'b0;
    end
  end

  // row major framebuffer address
  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr <= fb_addr_t'(gfx_y) * fb_addr_t'(H_VISIBLE) + fb_addr_t'(gfx_x);
      wr_data <= {gfx_color, gfx_meta};
    end
  end

  a_wr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wr_req && !wr_grant) |=> ($stable(wr_addr) && $stable(wr_data))
  ) else $error("pending write changed before grant");

endmodule

`default_nettype wire

// ==== fb_mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_mem_arbiter
  import gfx_vga_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rd_req,
  input  fb_addr_t rd_addr,
  output pixel_t   rd_data,
  input  logic     wr_req,
  input  fb_addr_t wr_addr,
  input  pixel_t   wr_data,
  output logic     wr_grant
);

  pixel_t mem [FB_DEPTH];

  // framebuffer comes up black
  initial begin
    for (int i = 0; i < FB_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // display always wins the single port
  assign wr_grant = wr_req && !rd_req;

  always @(posedge clk) begin
    if (wr_grant) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req) begin
      rd_data <= mem[rd_addr];
    end
  end

  a_port_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_req |-> !wr_grant
  ) else $error("write granted during display read");

endmodule

`default_nettype wire

// ==== vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing
  import gfx_vga_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    advance,
  output hcount_t hcount,
  output vcount_t vcount,
  output logic    visible,
  output logic    hsync,
  output logic    vsync
);

  logic line_end;
  logic frame_end;

  assign line_end  = (hcount == hcount_t'(H_WHOLE_LINE - 1));
  assign frame_end = (vcount == vcount_t'(V_WHOLE_FRAME - 1));

  // counters only move on enabled cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hcount <= '0;
      vcount <= '0;
    end else if (advance) begin
      if (line_end) begin
        hcount <= '0;
        if (frame_end) begin
          vcount <= '0;
        end else begin
          vcount <= vcount + 1'b1;
        end
      end else begin
        hcount <= hcount + 1'b1;
      end
    end
  end

  assign visible = (hcount < hcount_t'(H_VISIBLE)) && (vcount < vcount_t'(V_VISIBLE));

  // sync pulses sit right after the front porch, active low
  assign hsync = !((hcount >= hcount_t'(H_VISIBLE + H_FRONT_PORCH)) &&
                   (hcount < hcount_t'(H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE)));
  assign vsync = !((vcount >= vcount_t'(V_VISIBLE + V_FRONT_PORCH)) &&
                   (vcount < vcount_t'(V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE)));

endmodule

`default_nettype wire

// ==== vga_fb_pixel_stream.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_fb_pixel_stream
  import gfx_vga_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable,
  input  logic      almost_full,
  output logic      rd_req,
  output fb_addr_t  rd_addr,
  input  pixel_t    rd_data,
  output logic      fifo_wr,
  output vga_word_t fifo_wdata
);

  logic    advance;
  hcount_t hcount;
  vcount_t vcount;
  logic    visible;
  logic    hsync;
  logic    vsync;

  // position info waiting for its pixel to come back
  logic s1_valid;
  logic s1_visible;
  logic s1_hsync;
  logic s1_vsync;

  assign advance = enable && !almost_full;

  vga_timing vga_timing_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .advance(advance),
    .hcount (hcount),
    .vcount (vcount),
    .visible(visible),
    .hsync  (hsync),
    .vsync  (vsync)
  );

  // blanking positions need no memory access
  assign rd_req  = advance && visible;
  assign rd_addr = fb_addr_t'(vcount) * fb_addr_t'(H_VISIBLE) + fb_addr_t'(hcount);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= advance;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_visible <= visible;
      s1_hsync   <= hsync;
      s1_vsync   <= vsync;
    end
  end

  // rd_data lands this cycle, line it up with the sync bits
  assign fifo_wr    = s1_valid;
  assign fifo_wdata = {s1_hsync, s1_vsync, s1_visible ? rd_data : pixel_t'(0)};

  a_read_visible: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_req |-> visible ##1 (fifo_wr && s1_visible)
  ) else $error("display read outside the visible area");

endmodule

`default_nettype wire

// ==== cdc_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo
  import gfx_vga_pkg::*;
(
  input  logic      w_clk,
  input  logic      w_rst_n,
  input  logic      w_inc,
  input  vga_word_t w_data,
  output logic      w_almost_full,
  input  logic      r_clk,
  input  logic      r_rst_n,
  output logic      r_valid,
  output vga_word_t r_data
);

  vga_word_t mem [FIFO_DEPTH];

  logic [FIFO_ADDR_BITS:0] w_bin;
  logic [FIFO_ADDR_BITS:0] w_bin_inc;
  logic [FIFO_ADDR_BITS:0] w_gray;
  logic [FIFO_ADDR_BITS:0] wq1_r_gray;
  logic [FIFO_ADDR_BITS:0] wq2_r_gray;
  logic [FIFO_ADDR_BITS:0] w_used;
  logic                    w_full;
  logic                    w_push;

  logic [FIFO_ADDR_BITS:0] r_bin;
  logic [FIFO_ADDR_BITS:0] r_bin_inc;
  logic [FIFO_ADDR_BITS:0] r_gray;
  logic [FIFO_ADDR_BITS:0] rq1_w_gray;
  logic [FIFO_ADDR_BITS:0] rq2_w_gray;
  logic                    r_empty;

  function automatic logic [FIFO_ADDR_BITS:0] gray2bin(input logic [FIFO_ADDR_BITS:0] g);
    logic [FIFO_ADDR_BITS:0] b;
    b[FIFO_ADDR_BITS] = g[FIFO_ADDR_BITS];
    for (int i = FIFO_ADDR_BITS - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // write side
  assign w_bin_inc = w_bin + 1'b1;
  assign w_used    = w_bin - gray2bin(wq2_r_gray);
  // used count tops out at FIFO_DEPTH, so the msb means full
  assign w_full        = w_used[FIFO_ADDR_BITS];
  assign w_almost_full = (w_used >= FIFO_DEPTH - FIFO_ALMOST_FULL_BUF);
  assign w_push        = w_inc && !w_full;

  always_ff @(posedge w_clk or negedge w_rst_n) begin
    if (!w_rst_n) begin
      w_bin  <= '0;
      w_gray <= '0;
    end else if (w_push) begin
      w_bin  <= w_bin_inc;
      w_gray <= w_bin_inc ^ (w_bin_inc >> 1);
    end
  end

  always_ff @(posedge w_clk) begin
    if (w_push) begin
      mem[w_bin[FIFO_ADDR_BITS-1:0]] <= w_data;
    end
  end

  always_ff @(posedge w_clk or negedge w_rst_n) begin
    if (!w_rst_n) begin
      wq1_r_gray <= '0;
      wq2_r_gray <= '0;
    end else begin
      wq1_r_gray <= r_gray;
      wq2_r_gray <= wq1_r_gray;
    end
  end

  // read side pops on every non-empty cycle
  assign r_bin_inc = r_bin + 1'b1;
  assign r_empty   = (r_gray == rq2_w_gray);

  always_ff @(posedge r_clk or negedge r_rst_n) begin
    if (!r_rst_n) begin
      r_bin   <= '0;
      r_gray  <= '0;
      r_valid <= 1'b0;
    end else begin
      r_valid <= !r_empty;
      if (!r_empty) begin
        r_bin  <= r_bin_inc;
        r_gray <= r_bin_inc ^ (r_bin_inc >> 1);
      end
    end
  end

  always_ff @(posedge r_clk) begin
    if (!r_empty) begin
      r_data <= mem[r_bin[FIFO_ADDR_BITS-1:0]];
    end
  end

  always_ff @(posedge r_clk or negedge r_rst_n) begin
    if (!r_rst_n) begin
      rq1_w_gray <= '0;
      rq2_w_gray <= '0;
    end else begin
      rq1_w_gray <= w_gray;
      rq2_w_gray <= rq1_w_gray;
    end
  end

  // writer must back off on almost full well before this
  a_no_push_full: assert property (
    @(posedge w_clk) disable iff (!w_rst_n)
    w_full |-> !w_inc
  ) else $error("fifo write while full");

endmodule

`default_nettype wire

// ==== gfx_vga_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gfx_vga_top
  import gfx_vga_pkg::*;
(
  input  logic                    clk,
  input  logic                    pixel_clk,
  input  logic                    rst_n,
  input  fb_x_t                   gfx_x,
  input  fb_y_t                   gfx_y,
  input  logic [3*COLOR_BITS-1:0] gfx_color,
  input  meta_t                   gfx_meta,
  input  logic                    gfx_valid,
  output logic                    gfx_ready,
  output logic                    gfx_vsync,
  input  logic                    vga_enable,
  output logic                    vga_valid,
  output color_t                  vga_red,
  output color_t                  vga_grn,
  output color_t                  vga_blu,
  output meta_t                   vga_meta,
  output logic                    vga_hsync,
  output logic                    vga_vsync
);

  logic      wr_req;
  fb_addr_t  wr_addr;
  pixel_t    wr_data;
  logic      wr_grant;
  logic      rd_req;
  fb_addr_t  rd_addr;
  pixel_t    rd_data;
  logic      fifo_wr;
  vga_word_t fb_word;
  logic      fifo_almost_full;
  vga_word_t vga_word;

  fb_writer fb_writer_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .gfx_x    (gfx_x),
    .gfx_y    (gfx_y),
    .gfx_color(gfx_color),
    .gfx_meta (gfx_meta),
    .gfx_valid(gfx_valid),
    .gfx_ready(gfx_ready),
    .wr_req   (wr_req),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_grant (wr_grant)
  );

  fb_mem_arbiter fb_mem_arbiter_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_req  (wr_req),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_grant(wr_grant)
  );

  vga_fb_pixel_stream vga_fb_pixel_stream_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (vga_enable),
    .almost_full(fifo_almost_full),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .fifo_wr    (fifo_wr),
    .fifo_wdata (fb_word)
  );

  // vsync back to the drawing client, still in clk domain
  assign gfx_vsync = fb_word[PIXEL_BITS];

  cdc_fifo cdc_fifo_inst (
    .w_clk        (clk),
    .w_rst_n      (rst_n),
    .w_inc        (fifo_wr),
    .w_data       (fb_word),
    .w_almost_full(fifo_almost_full),
    .r_clk        (pixel_clk),
    .r_rst_n      (rst_n),
    .r_valid      (vga_valid),
    .r_data       (vga_word)
  );

  assign {vga_hsync, vga_vsync, vga_red, vga_grn, vga_blu, vga_meta} = vga_word;

endmodule

`default_nettype wire

// ==== tb_gfx_vga.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_vga
  import gfx_vga_pkg::*;
;

  localparam logic [31:0] SEED = 32'hce51;
  localparam int ROUNDS = 4;
  localparam int WRITES = 64;
  localparam int CYCLE_LIMIT = ROUNDS * (WRITES * 4 + 3 * FRAME_POSITIONS * 3) * 2;

  logic                    clk;
  logic                    pixel_clk;
  logic                    rst_n;
  fb_x_t                   gfx_x;
  fb_y_t                   gfx_y;
  logic [3*COLOR_BITS-1:0] gfx_color;
  meta_t                   gfx_meta;
  logic                    gfx_valid;
  logic                    gfx_ready;
  logic                    gfx_vsync;
  logic                    vga_enable;
  logic                    vga_valid;
  color_t                  vga_red;
  color_t                  vga_grn;
  color_t                  vga_blu;
  meta_t                   vga_meta;
  logic                    vga_hsync;
  logic                    vga_vsync;

  // two streams so the enable toggling does not disturb the draw sequence
  logic [31:0] lfsr_q [2];
  pixel_t      fb_model [FB_DEPTH];
  logic        toggle_enable = 1'b0;
  int          out_pos = 0;
  int          frames_seen = 0;
  int          check_first = 1 << 30;
  int          check_last = 0;
  int          cycle_count = 0;
  logic        gfx_vsync_q;
  int          vsync_falls_in = 0;
  int          vsync_falls_out = 0;

  gfx_vga_top dut0 (
    .clk       (clk),
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_meta  (gfx_meta),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .gfx_vsync (gfx_vsync),
    .vga_enable(vga_enable),
    .vga_valid (vga_valid),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_meta  (vga_meta),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  initial pixel_clk = 1'b0;
  always #5 pixel_clk = ~pixel_clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int unsigned take_bits(input int src, input int n);
    int unsigned val;
    int i;
    val = 0;
    for (i = 0; i < n; i++) begin
      val = (val << 1) | lfsr_q[src][31];
      lfsr_q[src] = lfsr_step(lfsr_q[src]);
    end
    return val;
  endfunction

  // raster rules for a position counted from the frame start
  function automatic logic exp_hsync(input int pos);
    int h;
    h = pos % H_WHOLE_LINE;
    return !(h >= H_VISIBLE + H_FRONT_PORCH && h < H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE);
  endfunction

  function automatic logic exp_vsync(input int pos);
    int v;
    v = pos / H_WHOLE_LINE;
    return !(v >= V_VISIBLE + V_FRONT_PORCH && v < V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE);
  endfunction

  function automatic logic in_visible(input int pos);
    return (pos % H_WHOLE_LINE < H_VISIBLE) && (pos / H_WHOLE_LINE < V_VISIBLE);
  endfunction

  function automatic int pos_to_addr(input int pos);
    return (pos / H_WHOLE_LINE) * H_VISIBLE + pos % H_WHOLE_LINE;
  endfunction

  task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                       input string what);
    if (expected !== actual) begin
      $display("MISMATCH at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // holds gfx_valid until the writer takes the pixel
  task automatic write_pixel(input fb_x_t x, input fb_y_t y,
                             input logic [3*COLOR_BITS-1:0] color, input meta_t meta);
    logic accepted;
    accepted = 1'b0;
    gfx_x = x;
    gfx_y = y;
    gfx_color = color;
    gfx_meta = meta;
    gfx_valid = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      accepted = gfx_ready;
      @(posedge clk);
      #1;
    end
    fb_model[int'(y) * H_VISIBLE + int'(x)] = {color, meta};
  endtask

  always @(posedge clk) begin
    #1;
    if (toggle_enable) begin
      vga_enable = (take_bits(1, 2) != 0);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not complete within %0d clk cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $fatal(1, "simulation timed out");
    end
  end

  // frame sync starts leaving the stream, before the FIFO
  always @(negedge clk) begin
    if (rst_n && gfx_vsync_q === 1'b1 && gfx_vsync === 1'b0) begin
      vsync_falls_in++;
    end
    gfx_vsync_q = gfx_vsync;
  end

  // output monitor, one raster position per valid word
  always @(negedge pixel_clk) begin
    if (rst_n && vga_valid) begin
      if (out_pos == 0) begin
        frames_seen++;
      end
      check(exp_hsync(out_pos), vga_hsync, $sformatf("hsync at position %0d", out_pos));
      check(exp_vsync(out_pos), vga_vsync, $sformatf("vsync at position %0d", out_pos));
      // each output frame sync was seen once on gfx_vsync, the next one not yet
      if (out_pos == (V_VISIBLE + V_FRONT_PORCH) * H_WHOLE_LINE) begin
        vsync_falls_out++;
        check(vsync_falls_out, vsync_falls_in, "gfx_vsync frame sync count");
      end
      if (!in_visible(out_pos)) begin
        check(0, {vga_red, vga_grn, vga_blu, vga_meta},
              $sformatf("blanking pixel at position %0d", out_pos));
      end else if (frames_seen >= check_first && frames_seen <= check_last) begin
        check(fb_model[pos_to_addr(out_pos)], {vga_red, vga_grn, vga_blu, vga_meta},
              $sformatf("pixel at position %0d", out_pos));
      end
      out_pos = (out_pos == FRAME_POSITIONS - 1) ? 0 : out_pos + 1;
    end
  end

  initial begin
    fb_x_t                   x;
    fb_y_t                   y;
    logic [3*COLOR_BITS-1:0] color;
    meta_t                   meta;
    int                      gap;
    int                      f0;
    rst_n = 1'b1;
    gfx_x = '0;
    gfx_y = '0;
    gfx_color = '0;
    gfx_meta = '0;
    gfx_valid = 1'b0;
    vga_enable = 1'b0;
    lfsr_q[0] = SEED;
    lfsr_q[1] = SEED;
    x = '0;
    y = '0;
    for (int i = 0; i < FB_DEPTH; i++) begin
      fb_model[i] = '0;
    end

    // reset falls just after time zero
    #1;
    rst_n = 1'b0;
    repeat (16) begin
      @(posedge clk);
      #1;
      check(0, vga_valid, "vga_valid during reset");
      check(1, gfx_ready, "gfx_ready during reset");
    end
    rst_n = 1'b1;
    @(negedge clk);
    check(0, vga_valid, "vga_valid right after reset");
    check(1, gfx_ready, "gfx_ready right after reset");
    toggle_enable = 1'b1;

    for (int round = 0; round < ROUNDS; round++) begin
      @(posedge clk);
      #1;
      for (int n = 0; n < WRITES; n++) begin
        // a quarter of the writes land on the previous address again
        if (n == 0 || take_bits(0, 2) != 0) begin
          x = fb_x_t'(take_bits(0, 4));
          y = fb_y_t'(take_bits(0, 3));
        end
        color = take_bits(0, 3 * COLOR_BITS);
        meta = meta_t'(take_bits(0, META_BITS));
        write_pixel(x, y, color, meta);
        gap = take_bits(0, 2);
        if (gap > 0) begin
          gfx_valid = 1'b0;
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
        end
      end
      gfx_valid = 1'b0;

      // skip the frame already in flight, then compare two whole frames
      f0 = frames_seen;
      check_first = f0 + 2;
      check_last = f0 + 3;
      wait (frames_seen > check_last);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
gfx_vga_pkg.sv
fb_writer.sv
fb_mem_arbiter.sv
vga_timing.sv
vga_fb_pixel_stream.sv
cdc_fifo.sv
gfx_vga_top.sv
tb_gfx_vga.sv
